/* Bender.yml */
package:
  name: alu_cluster

sources:
  - rtl/alu_pkg.sv
  - rtl/operand_forward.sv
  - rtl/op_decode.sv
  - rtl/int_alu.sv
  - rtl/alu_shifter.sv
  - rtl/alu_lane.sv
  - rtl/alu_cluster.sv
  - target: simulation
    files:
      - dv/alu_cluster_checker.sv
      - dv/alu_cluster_tb.sv

/* dv/alu_cluster_checker.sv */
`timescale 1ns/1ps

module alu_cluster_checker #(
  parameter int NUM_LANES = 2
) (
  input logic            clk,
  input logic            reset,
  input logic            issue [NUM_LANES],
  input logic            result_valid [NUM_LANES],
  input alu_pkg::data_t  result_data [NUM_LANES],
  input alu_pkg::flags_t result_flags [NUM_LANES]
);

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    // quiet during reset and for one more cycle
    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> !result_valid[l] ##1 !result_valid[l])
      else $error("lane %0d result_valid high around reset", l);

    a_valid_two_edges: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(reset, 2)) |-> result_valid[l] == $past(issue[l], 2))
      else $error("lane %0d result_valid does not follow issue by two edges", l);

    // narrow results are zero-extended, so the full word works for both widths
    a_zero_flag: assert property (@(posedge clk) disable iff (reset)
        result_valid[l] |-> result_flags[l].zero == (result_data[l] == '0))
      else $error("lane %0d zero flag disagrees with result", l);
  end

endmodule

/* dv/alu_cluster_tb.sv */
`timescale 1ns/1ps

module alu_cluster_tb;

  import alu_pkg::*;

  localparam int NUM_LANES = 2;
  localparam int NUM_BUS = 4;
  localparam int DRAIN_LIMIT = 20;

  logic   clk;
  logic   reset;
  logic   issue [NUM_LANES];
  op_t    op [NUM_LANES];
  logic   narrow [NUM_LANES];
  data_t  a [NUM_LANES];
  data_t  b [NUM_LANES];
  flags_t flags_in [NUM_LANES];
  src_t   a_sel_now [NUM_LANES];
  src_t   a_sel_late [NUM_LANES];
  src_t   b_sel_now [NUM_LANES];
  src_t   b_sel_late [NUM_LANES];
  src_t   f_sel_now [NUM_LANES];
  src_t   f_sel_late [NUM_LANES];
  data_t  bypass_data [NUM_BUS];
  flags_t bypass_flags [NUM_BUS];
  logic   result_valid [NUM_LANES];
  data_t  result_data [NUM_LANES];
  flags_t result_flags [NUM_LANES];

  data_t       bus_data_prev [NUM_BUS]; // buses as the DUT latched them last edge
  flags_t      bus_flags_prev [NUM_BUS];
  logic [67:0] exp_q [NUM_LANES][$];    // {data, flags} per pending op
  int          seed = 32'h788d;
  int          num_checked = 0;
  int          waited;

  alu_cluster #(.NUM_LANES(NUM_LANES), .NUM_BUS(NUM_BUS)) dut0 (
    .clk(clk), .reset(reset), .issue(issue), .op(op), .narrow(narrow),
    .a(a), .b(b), .flags_in(flags_in),
    .a_sel_now(a_sel_now), .a_sel_late(a_sel_late),
    .b_sel_now(b_sel_now), .b_sel_late(b_sel_late),
    .f_sel_now(f_sel_now), .f_sel_late(f_sel_late),
    .bypass_data(bypass_data), .bypass_flags(bypass_flags),
    .result_valid(result_valid), .result_data(result_data),
    .result_flags(result_flags));

  bind alu_cluster alu_cluster_checker #(.NUM_LANES(NUM_LANES)) u_checker (
    .clk(clk), .reset(reset), .issue(issue), .result_valid(result_valid),
    .result_data(result_data), .result_flags(result_flags));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  // mostly corner values so carry, overflow and shift limits get hit often
  function automatic data_t pick_value();
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    r = $random(seed);
    hi = $random(seed);
    lo = $random(seed);
    case (r[3:0])
      4'd0: return '0;
      4'd1: return '1;
      4'd2: return 64'h8000_0000_0000_0000;
      4'd3: return 64'h7fff_ffff_ffff_ffff;
      4'd4: return 64'h0000_0000_ffff_ffff;
      4'd5: return 64'h0000_0000_8000_0000;
      4'd6: return 64'h0000_0000_7fff_ffff;
      4'd7: return 64'd1;
      default: return {hi, lo};
    endcase
  endfunction

  function automatic src_t pick_select();
    logic [31:0] r;
    r = $random(seed);
    if (r[0]) return SRC_NONE;
    return src_t'(r[7:1] % NUM_BUS);
  endfunction

  function automatic data_t forward_data(src_t now, src_t late, data_t reg_val);
    if (now != SRC_NONE) return bypass_data[now];
    if (late != SRC_NONE) return bus_data_prev[late];
    return reg_val;
  endfunction

  function automatic flags_t forward_flags(src_t now, src_t late, flags_t reg_val);
    if (now != SRC_NONE) return bypass_flags[now];
    if (late != SRC_NONE) return bus_flags_prev[late];
    return reg_val;
  endfunction

  function automatic logic [67:0] expected_result(op_t opc, logic nar, data_t x, data_t y,
                                                  flags_t f);
    logic [64:0] uw;
    logic [64:0] sw;
    logic [32:0] un;
    logic [32:0] sn;
    logic [31:0] r32;
    logic [5:0]  cnt;
    logic        cin;
    logic        c64;
    logic        c32;
    data_t       res;
    flags_t      fl;
    cin = (opc == OP_ADC) && f.carry;
    cnt = nar ? {1'b0, y[4:0]} : y[5:0];
    fl = '0;
    res = '0;
    uw = '0;
    sw = '0;
    un = '0;
    sn = '0;
    c64 = 1'b0;
    c32 = 1'b0;
    case (opc)
      OP_ADD, OP_ADC: begin
        uw = {1'b0, x} + {1'b0, y} + cin;
        sw = {x[63], x} + {y[63], y} + cin;
        un = {1'b0, x[31:0]} + {1'b0, y[31:0]} + cin;
        sn = {x[31], x[31:0]} + {y[31], y[31:0]} + cin;
        c64 = uw[64];
        c32 = un[32];
        res = uw[63:0];
      end
      OP_SUB: begin
        uw = {1'b0, x} - {1'b0, y};
        sw = {x[63], x} - {y[63], y};
        un = {1'b0, x[31:0]} - {1'b0, y[31:0]};
        sn = {x[31], x[31:0]} - {y[31], y[31:0]};
        c64 = !uw[64]; // top bit is the borrow
        c32 = !un[32];
        res = uw[63:0];
      end
      OP_AND: res = x & y;
      OP_OR:  res = x | y;
      OP_XOR: res = x ^ y;
      OP_SHL: begin
        r32 = x[31:0] << cnt;
        if (nar) res = {32'b0, r32};
        else res = x << cnt;
      end
      OP_SHR: begin
        r32 = x[31:0] >> cnt;
        if (nar) res = {32'b0, r32};
        else res = x >> cnt;
      end
      default: begin
        r32 = $signed(x[31:0]) >>> cnt;
        if (nar) res = {32'b0, r32};
        else res = $signed(x) >>> cnt;
      end
    endcase
    if (opc == OP_ADD || opc == OP_ADC || opc == OP_SUB) begin
      fl.carry = nar ? c32 : c64;
      fl.overflow = nar ? (sn[32] ^ sn[31]) : (sw[64] ^ sw[63]);
    end
    if (nar) res = {32'b0, res[31:0]};
    fl.zero = nar ? (res[31:0] == '0) : (res == '0);
    fl.sign = nar ? res[31] : res[63];
    return {res, fl};
  endfunction

  task automatic drive_cycle(input bit use_fwd, input bit allow_idle);
    logic [31:0] r;
    logic [3:0]  code;
    data_t       fa;
    data_t       fb;
    flags_t      ff;
    for (int i = 0; i < NUM_BUS; i++) begin
      bus_data_prev[i] = bypass_data[i];
      bus_flags_prev[i] = bypass_flags[i];
      r = $random(seed);
      bypass_data[i] = pick_value();
      bypass_flags[i] = r[3:0];
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      r = $random(seed);
      code = r[15:8] % 9;
      issue[l] = allow_idle ? (r[1:0] != 2'b00) : 1'b1;
      narrow[l] = r[2];
      op[l] = op_t'(code);
      flags_in[l] = r[19:16];
      a[l] = pick_value();
      b[l] = pick_value();
      a_sel_now[l] = use_fwd ? pick_select() : SRC_NONE;
      a_sel_late[l] = use_fwd ? pick_select() : SRC_NONE;
      b_sel_now[l] = use_fwd ? pick_select() : SRC_NONE;
      b_sel_late[l] = use_fwd ? pick_select() : SRC_NONE;
      f_sel_now[l] = use_fwd ? pick_select() : SRC_NONE;
      f_sel_late[l] = use_fwd ? pick_select() : SRC_NONE;
      if (issue[l]) begin
        fa = forward_data(a_sel_now[l], a_sel_late[l], a[l]);
        fb = forward_data(b_sel_now[l], b_sel_late[l], b[l]);
        ff = forward_flags(f_sel_now[l], f_sel_late[l], flags_in[l]);
        exp_q[l].push_back(expected_result(op[l], narrow[l], fa, fb, ff));
      end
    end
  endtask

  function automatic int pending_results();
    int n;
    n = 0;
    for (int l = 0; l < NUM_LANES; l++) n += exp_q[l].size();
    return n;
  endfunction

  // outputs are steady at the falling edge
  always @(negedge clk) begin : compare_results
    logic [67:0] want;
    if (!reset) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (result_valid[l]) begin
          assert (exp_q[l].size() > 0)
            else report_failure($sformatf("lane %0d gave a result with nothing issued", l));
          want = exp_q[l].pop_front();
          assert (result_data[l] == want[67:4])
            else report_failure($sformatf("error at %0t: result_data[%0d] got %h expected %h",
                                          $time, l, result_data[l], want[67:4]));
          assert (result_flags[l] == want[3:0])
            else report_failure($sformatf("error at %0t: result_flags[%0d] got %b expected %b",
                                          $time, l, result_flags[l], want[3:0]));
          num_checked++;
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    for (int l = 0; l < NUM_LANES; l++) begin
      issue[l] = 1'b0;
      op[l] = OP_ADD;
      narrow[l] = 1'b0;
      a[l] = '0;
      b[l] = '0;
      flags_in[l] = '0;
      a_sel_now[l] = SRC_NONE;
      a_sel_late[l] = SRC_NONE;
      b_sel_now[l] = SRC_NONE;
      b_sel_late[l] = SRC_NONE;
      f_sel_now[l] = SRC_NONE;
      f_sel_late[l] = SRC_NONE;
    end
    for (int i = 0; i < NUM_BUS; i++) begin
      bypass_data[i] = '0;
      bypass_flags[i] = '0;
      bus_data_prev[i] = '0;
      bus_flags_prev[i] = '0;
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // register operands only, with idle gaps
    repeat (300) begin
      drive_cycle(1'b0, 1'b1);
      @(negedge clk);
    end
    repeat (400) begin
      drive_cycle(1'b1, 1'b1);
      @(negedge clk);
    end
    repeat (100) begin
      drive_cycle(1'b1, 1'b0); // back to back on every lane
      @(negedge clk);
    end
    for (int l = 0; l < NUM_LANES; l++) issue[l] = 1'b0;
    waited = 0;
    while (pending_results() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pending_results() != 0) begin
      report_failure("timeout: results still pending after the last issue");
    end else begin
      repeat (4) @(negedge clk); // any stray result_valid shows up here
      $display("checked %0d results", num_checked);
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* rtl/alu_cluster.sv */
`timescale 1ns/1ps

module alu_cluster #(
  parameter int NUM_LANES = 2,
  parameter int NUM_BUS = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            issue [NUM_LANES],
  input  alu_pkg::op_t    op [NUM_LANES],
  input  logic            narrow [NUM_LANES],
  input  alu_pkg::data_t  a [NUM_LANES],
  input  alu_pkg::data_t  b [NUM_LANES],
  input  alu_pkg::flags_t flags_in [NUM_LANES],
  input  alu_pkg::src_t   a_sel_now [NUM_LANES],
  input  alu_pkg::src_t   a_sel_late [NUM_LANES],
  input  alu_pkg::src_t   b_sel_now [NUM_LANES],
  input  alu_pkg::src_t   b_sel_late [NUM_LANES],
  input  alu_pkg::src_t   f_sel_now [NUM_LANES],
  input  alu_pkg::src_t   f_sel_late [NUM_LANES],
  input  alu_pkg::data_t  bypass_data [NUM_BUS],
  input  alu_pkg::flags_t bypass_flags [NUM_BUS],
  output logic            result_valid [NUM_LANES],
  output alu_pkg::data_t  result_data [NUM_LANES],
  output alu_pkg::flags_t result_flags [NUM_LANES]
);

  import alu_pkg::*;

  data_t  bypass_data_late [NUM_BUS];
  flags_t bypass_flags_late [NUM_BUS];

  if (NUM_BUS > NUM_BUS_MAX) begin : g_bus_check
    $error("NUM_BUS %0d exceeds what src_t can address", NUM_BUS);
  end

  // buses as they stood one cycle back, shared by all lanes
  always_ff @(posedge clk) begin
    bypass_data_late  <= bypass_data;
    bypass_flags_late <= bypass_flags;
  end

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    alu_lane #(.NUM_BUS(NUM_BUS)) u_lane (
      .clk(clk), .reset(reset), .issue(issue[l]), .op(op[l]), .narrow(narrow[l]),
      .a(a[l]), .b(b[l]), .flags_in(flags_in[l]),
      .a_sel_now(a_sel_now[l]), .a_sel_late(a_sel_late[l]),
      .b_sel_now(b_sel_now[l]), .b_sel_late(b_sel_late[l]),
      .f_sel_now(f_sel_now[l]), .f_sel_late(f_sel_late[l]),
      .bypass_data(bypass_data), .bypass_data_late(bypass_data_late),
      .bypass_flags(bypass_flags), .bypass_flags_late(bypass_flags_late),
      .result_valid(result_valid[l]), .result_data(result_data[l]),
      .result_flags(result_flags[l]));
  end

endmodule

/* rtl/alu_lane.sv */
`timescale 1ns/1ps

module alu_lane #(
  parameter int NUM_BUS = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            issue,
  input  alu_pkg::op_t    op,
  input  logic            narrow,
  input  alu_pkg::data_t  a,
  input  alu_pkg::data_t  b,
  input  alu_pkg::flags_t flags_in,
  input  alu_pkg::src_t   a_sel_now,
  input  alu_pkg::src_t   a_sel_late,
  input  alu_pkg::src_t   b_sel_now,
  input  alu_pkg::src_t   b_sel_late,
  input  alu_pkg::src_t   f_sel_now,
  input  alu_pkg::src_t   f_sel_late,
  input  alu_pkg::data_t  bypass_data [NUM_BUS],
  input  alu_pkg::data_t  bypass_data_late [NUM_BUS],
  input  alu_pkg::flags_t bypass_flags [NUM_BUS],
  input  alu_pkg::flags_t bypass_flags_late [NUM_BUS],
  output logic            result_valid,
  output alu_pkg::data_t  result_data,
  output alu_pkg::flags_t result_flags
);

  import alu_pkg::*;

  data_t      a_q, b_q, alu_sum, sh_data;
  flags_t     f_q, alu_flags, sh_flags;
  logic       valid, is_shift, is_sub, use_carry;
  logic       shift_right, shift_arith, narrow_q;
  logic_sel_t logic_sel;

  operand_forward #(.payload_t(data_t), .NUM_BUS(NUM_BUS)) u_fwd_a (
    .clk(clk), .reset(reset), .issue(issue), .reg_value(a),
    .sel_now(a_sel_now), .sel_late(a_sel_late),
    .bus_now(bypass_data), .bus_late(bypass_data_late), .operand(a_q));

  operand_forward #(.payload_t(data_t), .NUM_BUS(NUM_BUS)) u_fwd_b (
    .clk(clk), .reset(reset), .issue(issue), .reg_value(b),
    .sel_now(b_sel_now), .sel_late(b_sel_late),
    .bus_now(bypass_data), .bus_late(bypass_data_late), .operand(b_q));

  operand_forward #(.payload_t(flags_t), .NUM_BUS(NUM_BUS)) u_fwd_f (
    .clk(clk), .reset(reset), .issue(issue), .reg_value(flags_in),
    .sel_now(f_sel_now), .sel_late(f_sel_late),
    .bus_now(bypass_flags), .bus_late(bypass_flags_late), .operand(f_q));

  op_decode u_dec (
    .clk(clk), .reset(reset), .issue(issue), .op(op), .narrow(narrow),
    .valid(valid), .is_shift(is_shift), .is_sub(is_sub), .use_carry(use_carry),
    .logic_sel(logic_sel), .shift_right(shift_right), .shift_arith(shift_arith),
    .narrow_q(narrow_q));

  int_alu u_alu (
    .a(a_q), .b(b_q), .carry_in(f_q.carry), .is_sub(is_sub), .use_carry(use_carry),
    .logic_sel(logic_sel), .narrow(narrow_q), .sum(alu_sum), .flags(alu_flags));

  alu_shifter u_sh (
    .a(a_q), .count(b_q[SHIFT_W-1:0]), .shift_right(shift_right),
    .shift_arith(shift_arith), .narrow(narrow_q), .shifted(sh_data), .flags(sh_flags));

  always_ff @(posedge clk) begin
    if (reset) result_valid <= 1'b0;
    else result_valid <= valid;
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      result_data  <= is_shift ? sh_data : alu_sum;
      result_flags <= is_shift ? sh_flags : alu_flags;
    end
  end

endmodule

/* rtl/alu_pkg.sv */
package alu_pkg;

  localparam int DATA_W = 64;
  localparam int NARROW_W = 32;
  localparam int SHIFT_W = $clog2(DATA_W); // 6 count bits for the wide form

  // source select: 0..14 name a bypass bus, all ones means register value
  localparam int SRC_W = 4;
  localparam int NUM_BUS_MAX = 15;

  typedef logic [DATA_W-1:0] data_t;

  typedef logic [SRC_W-1:0] src_t;

  localparam src_t SRC_NONE = {SRC_W{1'b1}};

  // carry sits in bit 0
  typedef struct packed {
    logic overflow;
    logic sign;
    logic zero;
    logic carry; // for sub this is "no borrow"
  } flags_t;

  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_ADC = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_SHL = 4'd6,
    OP_SHR = 4'd7,
    OP_SAR = 4'd8
  } op_t;

  // result mux inside int_alu, none selects the adder
  typedef enum logic [1:0] {
    LOGIC_NONE = 2'd0,
    LOGIC_AND  = 2'd1,
    LOGIC_OR   = 2'd2,
    LOGIC_XOR  = 2'd3
  } logic_sel_t;

endpackage

/* rtl/alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter (
  input  alu_pkg::data_t               a,
  input  logic [alu_pkg::SHIFT_W-1:0]  count,
  input  logic                         shift_right,
  input  logic                         shift_arith,
  input  logic                         narrow,
  output alu_pkg::data_t               shifted,
  output alu_pkg::flags_t              flags
);

  import alu_pkg::*;

  logic [SHIFT_W-1:0] amt;
  data_t              ext;
  data_t              raw;

  // narrow form uses 5 count bits
  assign amt = narrow ? {1'b0, count[SHIFT_W-2:0]} : count;

  // narrow sar needs the bit 31 sign spread into the upper half
  assign ext = narrow ?
      {{(DATA_W-NARROW_W){shift_arith & a[NARROW_W-1]}}, a[NARROW_W-1:0]} : a;

  always_comb begin
    if (!shift_right) begin
      raw = ext << amt;
    end else if (shift_arith) begin
      raw = $signed(ext) >>> amt;
    end else begin
      raw = ext >> amt;
    end
  end

  always_comb begin
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    if (narrow) begin
      shifted    = {{(DATA_W-NARROW_W){1'b0}}, raw[NARROW_W-1:0]};
      flags.zero = raw[NARROW_W-1:0] == '0;
      flags.sign = raw[NARROW_W-1];
    end else begin
      shifted    = raw;
      flags.zero = raw == '0;
      flags.sign = raw[DATA_W-1];
    end
  end

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
  input  alu_pkg::data_t      a,
  input  alu_pkg::data_t      b,
  input  logic                carry_in,
  input  logic                is_sub,
  input  logic                use_carry,
  input  alu_pkg::logic_sel_t logic_sel,
  input  logic                narrow,
  output alu_pkg::data_t      sum,
  output alu_pkg::flags_t     flags
);

  import alu_pkg::*;

  data_t             b_eff;
  logic              cin;
  logic [DATA_W:0]   add_full;
  data_t             raw;
  logic              is_logic;
  logic              carry_wide;
  logic              carry_narrow;
  logic              ovf_wide;
  logic              ovf_narrow;

  assign b_eff = is_sub ? ~b : b; // a + ~b + 1 for sub
  assign cin = is_sub | (use_carry & carry_in);
  assign add_full = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, cin};

  // carry into bit 32 recovered from the wide sum
  assign carry_wide = add_full[DATA_W];
  assign carry_narrow = add_full[NARROW_W] ^ a[NARROW_W] ^ b_eff[NARROW_W];

  assign ovf_wide = (a[DATA_W-1] == b_eff[DATA_W-1]) &&
                    (add_full[DATA_W-1] != a[DATA_W-1]);
  assign ovf_narrow = (a[NARROW_W-1] == b_eff[NARROW_W-1]) &&
                      (add_full[NARROW_W-1] != a[NARROW_W-1]);

  assign is_logic = logic_sel != LOGIC_NONE;

  always_comb begin
    case (logic_sel)
      LOGIC_AND: raw = a & b;
      LOGIC_OR:  raw = a | b;
      LOGIC_XOR: raw = a ^ b;
      default:   raw = add_full[DATA_W-1:0];
    endcase
  end

  always_comb begin
    if (narrow) begin
      sum = {{(DATA_W-NARROW_W){1'b0}}, raw[NARROW_W-1:0]};
      flags.zero     = raw[NARROW_W-1:0] == '0;
      flags.sign     = raw[NARROW_W-1];
      flags.carry    = !is_logic && carry_narrow;
      flags.overflow = !is_logic && ovf_narrow;
    end else begin
      sum = raw;
      flags.zero     = raw == '0;
      flags.sign     = raw[DATA_W-1];
      flags.carry    = !is_logic && carry_wide;
      flags.overflow = !is_logic && ovf_wide;
    end
  end

endmodule

/* rtl/op_decode.sv */
`timescale 1ns/1ps

module op_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic                issue,
  input  alu_pkg::op_t        op,
  input  logic                narrow,
  output logic                valid,
  output logic                is_shift,
  output logic                is_sub,
  output logic                use_carry,
  output alu_pkg::logic_sel_t logic_sel,
  output logic                shift_right,
  output logic                shift_arith,
  output logic                narrow_q
);

  import alu_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid       <= 1'b0;
      is_shift    <= 1'b0;
      is_sub      <= 1'b0;
      use_carry   <= 1'b0;
      logic_sel   <= LOGIC_NONE;
      shift_right <= 1'b0;
      shift_arith <= 1'b0;
      narrow_q    <= 1'b0;
    end else begin
      valid <= issue;
      if (issue) begin
        is_shift    <= (op == OP_SHL) || (op == OP_SHR) || (op == OP_SAR);
        is_sub      <= op == OP_SUB;
        use_carry   <= op == OP_ADC;
        shift_right <= op != OP_SHL; // every shift but shl goes right
        shift_arith <= op == OP_SAR;
        narrow_q    <= narrow;
        case (op)
          OP_AND:  logic_sel <= LOGIC_AND;
          OP_OR:   logic_sel <= LOGIC_OR;
          OP_XOR:  logic_sel <= LOGIC_XOR;
          default: logic_sel <= LOGIC_NONE;
        endcase
      end
    end
  end

endmodule

/* rtl/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward #(
  parameter type payload_t = alu_pkg::data_t,
  parameter int NUM_BUS = 4
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           issue,
  input  payload_t       reg_value,
  input  alu_pkg::src_t  sel_now,
  input  alu_pkg::src_t  sel_late,
  input  payload_t       bus_now [NUM_BUS],
  input  payload_t       bus_late [NUM_BUS],
  output payload_t       operand
);

  import alu_pkg::*;

  payload_t chosen;

  // later loop wins, so a live bus beats a late one
  always_comb begin
    chosen = reg_value;
    for (int i = 0; i < NUM_BUS; i++) begin
      if (sel_late == src_t'(i)) begin
        chosen = bus_late[i];
      end
    end
    for (int i = 0; i < NUM_BUS; i++) begin
      if (sel_now == src_t'(i)) begin
        chosen = bus_now[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !reset) begin
      operand <= chosen; // held while the lane idles
    end
  end

endmodule

/* sources.f */
rtl/alu_pkg.sv
rtl/operand_forward.sv
rtl/op_decode.sv
rtl/int_alu.sv
rtl/alu_shifter.sv
rtl/alu_lane.sv
rtl/alu_cluster.sv
dv/alu_cluster_checker.sv
dv/alu_cluster_tb.sv
